/* hw/a2audio_cfg.svh */
`ifndef A2AUDIO_CFG_SVH
`define A2AUDIO_CFG_SVH

// Width of one channel word
`define A2A_SAMPLE_BITS 16
// Width of the sprite and Mockingboard levels
`define A2A_SRC_BITS 10

// Mix rule: speaker bit position and left shift of the 10-bit sources
`define A2A_SPK_BIT 12
`define A2A_SRC_SHIFT 3

// Frames buffered between mixer and serializer
`define A2A_FIFO_DEPTH 4

// Clock cycles per half bit clock period
`define A2A_BCLK_HALF 2
`define A2A_FRAME_BITS (2 * `A2A_SAMPLE_BITS)

`endif

/* hw/a2audio_pkg.sv */
`include "a2audio_cfg.svh"

package a2audio_pkg;

    // Unsigned level from the sprite chip or the Mockingboard
    typedef logic [`A2A_SRC_BITS-1:0] src_level_t;

    // Unsigned mixed channel word
    typedef logic [`A2A_SAMPLE_BITS-1:0] sample_t;

    // Left occupies the upper half so it goes out first
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_pair_t;

    // Mixer fills the channel view, serializer shifts the raw view
    typedef union packed {
        stereo_pair_t               ch;
        logic [`A2A_FRAME_BITS-1:0] raw;
    } audio_frame_u;

endpackage

/* hw/audio_mixer.sv */
`timescale 1ns/1ps
`include "a2audio_cfg.svh"

module audio_mixer (
    input  logic                      clk_logic_w,
    input  logic                      system_reset_n_w,
    input  logic                      sample_valid_i,
    input  logic                      speaker_i,
    input  logic                      speaker_en_i,
    input  a2audio_pkg::src_level_t   ssp_audio_i,
    input  a2audio_pkg::src_level_t   mb_audio_l_i,
    input  a2audio_pkg::src_level_t   mb_audio_r_i,
    output logic                      wr_o,
    output a2audio_pkg::audio_frame_u frame_o
);

    a2audio_pkg::sample_t spk_ext_w;
    a2audio_pkg::sample_t ssp_ext_w;
    a2audio_pkg::sample_t mb_l_ext_w;
    a2audio_pkg::sample_t mb_r_ext_w;
    a2audio_pkg::sample_t mix_l_w;
    a2audio_pkg::sample_t mix_r_w;

    // Speaker is a single bit placed at bit 12 when enabled
    always_comb begin
        spk_ext_w = '0;
        spk_ext_w[`A2A_SPK_BIT] = speaker_i & speaker_en_i;
    end

    // Zero-extend first, then scale the 10-bit sources by 8
    assign ssp_ext_w  = a2audio_pkg::sample_t'(ssp_audio_i) << `A2A_SRC_SHIFT;
    assign mb_l_ext_w = a2audio_pkg::sample_t'(mb_audio_l_i) << `A2A_SRC_SHIFT;
    assign mb_r_ext_w = a2audio_pkg::sample_t'(mb_audio_r_i) << `A2A_SRC_SHIFT;

    // Worst case is 4096 + 8184 + 8184, well inside 16 bits
    assign mix_l_w = spk_ext_w + ssp_ext_w + mb_l_ext_w;
    assign mix_r_w = spk_ext_w + ssp_ext_w + mb_r_ext_w;

    // Write strobe follows the input strobe by one cycle
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            wr_o <= 1'b0;
        end else begin
            wr_o <= sample_valid_i;
        end
    end

    // Frame word only changes when a new sample is captured
    always_ff @(posedge clk_logic_w) begin
        if (sample_valid_i) begin
            frame_o.ch.left  <= mix_l_w;
            frame_o.ch.right <= mix_r_w;
        end
    end

endmodule

/* hw/sample_fifo.sv */
`timescale 1ns/1ps
`include "a2audio_cfg.svh"

module sample_fifo (
    input  logic                      clk_logic_w,
    input  logic                      system_reset_n_w,
    input  logic                      wr_i,
    input  a2audio_pkg::audio_frame_u frame_i,
    input  logic                      pop_i,
    output a2audio_pkg::audio_frame_u frame_o,
    output logic                      empty_o,
    output logic                      overflow_o
);

    localparam int PtrW = $clog2(`A2A_FIFO_DEPTH);
    localparam int CntW = PtrW + 1;

    a2audio_pkg::audio_frame_u mem_r [`A2A_FIFO_DEPTH];

    logic [PtrW-1:0] wr_ptr_r;
    logic [PtrW-1:0] rd_ptr_r;
    logic [CntW-1:0] count_r;
    logic            full_w;
    logic            do_wr_w;
    logic            do_rd_w;

    function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(`A2A_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_w  = (count_r == CntW'(`A2A_FIFO_DEPTH));
    assign empty_o = (count_r == '0);

    // Writes into a full buffer are lost
    assign do_wr_w = wr_i && !full_w;
    assign do_rd_w = pop_i && !empty_o;

    // Show-ahead, head is valid whenever empty_o is low
    assign frame_o = mem_r[rd_ptr_r];

    always_ff @(posedge clk_logic_w) begin
        if (do_wr_w) begin
            mem_r[wr_ptr_r] <= frame_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            count_r    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr_w) begin
                wr_ptr_r <= ptr_next(wr_ptr_r);
            end
            if (do_rd_w) begin
                rd_ptr_r <= ptr_next(rd_ptr_r);
            end
            // Pop and write together leave the fill level unchanged
            case ({do_wr_w, do_rd_w})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            // Sticky until reset
            if (wr_i && full_w) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

/* hw/i2s_serializer.sv */
`timescale 1ns/1ps
`include "a2audio_cfg.svh"

module i2s_serializer (
    input  logic                      clk_logic_w,
    input  logic                      system_reset_n_w,
    input  a2audio_pkg::audio_frame_u frame_i,
    input  logic                      empty_i,
    output logic                      pop_o,
    output logic                      i2s_bclk_o,
    output logic                      i2s_lrclk_o,
    output logic                      i2s_data_o
);

    localparam int DivW = (`A2A_BCLK_HALF > 1) ? $clog2(`A2A_BCLK_HALF) : 1;

    logic [DivW-1:0]            div_cnt_r;
    logic                       first_r;
    logic [4:0]                 bit_cnt_r;
    logic [4:0]                 bit_next_w;
    logic [`A2A_FRAME_BITS-1:0] shift_r;
    logic                       tick_w;
    logic                       fall_w;
    logic                       frame_start_w;

    // End of a half bit clock period
    assign tick_w = (div_cnt_r == DivW'(`A2A_BCLK_HALF - 1));

    // First tick after reset acts as a falling edge while the bit clock
    // stays low, so the first frame starts two cycles after release
    assign fall_w = tick_w && (i2s_bclk_o || first_r);

    // Counter parks at 31 in reset so the first fall opens a frame
    assign frame_start_w = fall_w && (bit_cnt_r == 5'd31);
    assign bit_next_w    = bit_cnt_r + 5'd1;

    // Single-cycle pop, head frame is consumed in the same cycle
    assign pop_o = frame_start_w && !empty_i;

    // MSB first, left word leads
    assign i2s_data_o = shift_r[`A2A_FRAME_BITS-1];

    // Half-period divider and bit clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            div_cnt_r  <= '0;
            i2s_bclk_o <= 1'b0;
            first_r    <= 1'b1;
        end else begin
            if (tick_w) begin
                div_cnt_r <= '0;
                if (first_r) begin
                    first_r <= 1'b0;
                end else begin
                    i2s_bclk_o <= ~i2s_bclk_o;
                end
            end else begin
                div_cnt_r <= div_cnt_r + 1'b1;
            end
        end
    end

    // Bit index within the frame and word clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            bit_cnt_r   <= '1;
            i2s_lrclk_o <= 1'b0;
        end else if (fall_w) begin
            bit_cnt_r <= bit_next_w;
            // Low for bits 0..15 (left), high for 16..31 (right)
            i2s_lrclk_o <= bit_next_w[4];
        end
    end

    // Shift register, loads a frame or silence at each frame start
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            shift_r <= '0;
        end else if (fall_w) begin
            if (frame_start_w) begin
                shift_r <= empty_i ? '0 : frame_i.raw;
            end else begin
                shift_r <= {shift_r[`A2A_FRAME_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

/* hw/a2audio_top.sv */
`timescale 1ns/1ps
`include "a2audio_cfg.svh"

module a2audio_top (
    input  logic                    clk_logic_w,
    input  logic                    system_reset_n_w,
    input  logic                    sample_valid_i,
    input  logic                    speaker_i,
    input  logic                    speaker_en_i,
    input  a2audio_pkg::src_level_t ssp_audio_i,
    input  a2audio_pkg::src_level_t mb_audio_l_i,
    input  a2audio_pkg::src_level_t mb_audio_r_i,
    output logic                    i2s_bclk_o,
    output logic                    i2s_lrclk_o,
    output logic                    i2s_data_o,
    output logic                    overflow_o
);

    // Mixer to buffer
    logic                      mix_wr_w;
    a2audio_pkg::audio_frame_u mix_frame_w;

    // Buffer to serializer
    a2audio_pkg::audio_frame_u head_frame_w;
    logic                      fifo_empty_w;
    logic                      ser_pop_w;

    audio_mixer u_mixer (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .sample_valid_i   (sample_valid_i),
        .speaker_i        (speaker_i),
        .speaker_en_i     (speaker_en_i),
        .ssp_audio_i      (ssp_audio_i),
        .mb_audio_l_i     (mb_audio_l_i),
        .mb_audio_r_i     (mb_audio_r_i),
        .wr_o             (mix_wr_w),
        .frame_o          (mix_frame_w)
    );

    sample_fifo u_fifo (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .wr_i             (mix_wr_w),
        .frame_i          (mix_frame_w),
        .pop_i            (ser_pop_w),
        .frame_o          (head_frame_w),
        .empty_o          (fifo_empty_w),
        .overflow_o       (overflow_o)
    );

    i2s_serializer u_serializer (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .frame_i          (head_frame_w),
        .empty_i          (fifo_empty_w),
        .pop_o            (ser_pop_w),
        .i2s_bclk_o       (i2s_bclk_o),
        .i2s_lrclk_o      (i2s_lrclk_o),
        .i2s_data_o       (i2s_data_o)
    );

endmodule

/* bench/a2audio_tb.sv */
`timescale 1ns/1ps
`include "a2audio_cfg.svh"

module a2audio_tb;

    // Two half periods per bit and 32 bits per frame
    localparam int FRAME_CYCLES   = 2 * `A2A_BCLK_HALF * `A2A_FRAME_BITS;
    localparam int TEST_FRAMES    = 45;
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES + 2240;

    logic                    clk_logic_w;
    logic                    system_reset_n_w;
    logic                    sample_valid_i;
    logic                    speaker_i;
    logic                    speaker_en_i;
    a2audio_pkg::src_level_t ssp_audio_i;
    a2audio_pkg::src_level_t mb_audio_l_i;
    a2audio_pkg::src_level_t mb_audio_r_i;
    logic                    i2s_bclk_o;
    logic                    i2s_lrclk_o;
    logic                    i2s_data_o;
    logic                    overflow_o;

    a2audio_pkg::audio_frame_u frames_q[$];
    a2audio_pkg::audio_frame_u exp_q[$];
    a2audio_pkg::audio_frame_u rx_frame;
    logic [31:0]               rx_shift;
    int                        rx_bit;
    logic [31:0]               rng_state;
    int                        cycle_cnt;
    int                        frame_errs;
    int                        flag_errs;
    int                        other_errs;

    a2audio_top dut (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .sample_valid_i   (sample_valid_i),
        .speaker_i        (speaker_i),
        .speaker_en_i     (speaker_en_i),
        .ssp_audio_i      (ssp_audio_i),
        .mb_audio_l_i     (mb_audio_l_i),
        .mb_audio_r_i     (mb_audio_r_i),
        .i2s_bclk_o       (i2s_bclk_o),
        .i2s_lrclk_o      (i2s_lrclk_o),
        .i2s_data_o       (i2s_data_o),
        .overflow_o       (overflow_o)
    );

    initial clk_logic_w = 1'b0;
    always #4 clk_logic_w = ~clk_logic_w;

    always @(posedge clk_logic_w) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d clock cycles, run aborted", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected mix with the speaker worth 4096 and each source level times 8
    function automatic a2audio_pkg::audio_frame_u mix_model(
        input logic spk, input logic en, input a2audio_pkg::src_level_t ssp,
        input a2audio_pkg::src_level_t mbl, input a2audio_pkg::src_level_t mbr);
        a2audio_pkg::audio_frame_u f;
        int                        spk_term;
        spk_term   = (spk && en) ? 4096 : 0;
        f.ch.left  = 16'(spk_term + 8 * int'(ssp) + 8 * int'(mbl));
        f.ch.right = 16'(spk_term + 8 * int'(ssp) + 8 * int'(mbr));
        return f;
    endfunction

    task automatic check_frame(input string what, input a2audio_pkg::audio_frame_u got,
                               input a2audio_pkg::audio_frame_u exp);
        if (got.raw !== exp.raw) begin
            frame_errs++;
            $display("error at %0t ns: %s: got L=%h R=%h, expected L=%h R=%h", $time, what,
                     got.ch.left, got.ch.right, exp.ch.left, exp.ch.right);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Deserializer samples MSB first on the rising bit clock
    always @(posedge i2s_bclk_o) begin
        check_flag("word clock level", i2s_lrclk_o, rx_bit >= 16);
        rx_shift = {rx_shift[30:0], i2s_data_o};
        if (rx_bit == 31) begin
            rx_frame.raw = rx_shift;
            frames_q.push_back(rx_frame);
            rx_bit = 0;
        end else begin
            rx_bit++;
        end
    end

    task automatic apply_reset;
        @(negedge clk_logic_w);
        system_reset_n_w = 1'b0;
        sample_valid_i   = 1'b0;
        repeat (2) @(negedge clk_logic_w);
        check_flag("bclk in reset", i2s_bclk_o, 1'b0);
        check_flag("lrclk in reset", i2s_lrclk_o, 1'b0);
        check_flag("data in reset", i2s_data_o, 1'b0);
        check_flag("overflow in reset", overflow_o, 1'b0);
        frames_q.delete();
        exp_q.delete();
        rx_bit           = 0;
        system_reset_n_w = 1'b1;
    endtask

    task automatic wait_frame(output a2audio_pkg::audio_frame_u f);
        while (frames_q.size() == 0) begin
            @(posedge clk_logic_w);
        end
        f = frames_q.pop_front();
    endtask

    // Starts on a falling clock edge and returns on the next one
    task automatic push_sample(input logic spk, input logic en,
                               input a2audio_pkg::src_level_t ssp,
                               input a2audio_pkg::src_level_t mbl,
                               input a2audio_pkg::src_level_t mbr);
        sample_valid_i = 1'b1;
        speaker_i      = spk;
        speaker_en_i   = en;
        ssp_audio_i    = ssp;
        mb_audio_l_i   = mbl;
        mb_audio_r_i   = mbr;
        exp_q.push_back(mix_model(spk, en, ssp, mbl, mbr));
        @(negedge clk_logic_w);
    endtask

    task automatic wait_nonzero(input string what, output a2audio_pkg::audio_frame_u f);
        int n;
        n = 0;
        wait_frame(f);
        while (f.raw == '0 && n < 4) begin
            wait_frame(f);
            n++;
        end
        if (f.raw == '0) begin
            other_errs++;
            $display("%s: no non-zero frame arrived within five frames", what);
        end
    endtask

    task automatic idle_after_reset;
        a2audio_pkg::audio_frame_u got;
        repeat (3) begin
            wait_frame(got);
            check_frame("idle frame", got, '0);
        end
        check_flag("idle overflow", overflow_o, 1'b0);
    endtask

    task automatic single_mix;
        a2audio_pkg::audio_frame_u got;
        @(negedge clk_logic_w);
        push_sample(1'b1, 1'b1, 10'h155, 10'h0a3, 10'h2f0);
        sample_valid_i = 1'b0;
        wait_nonzero("single mix", got);
        check_frame("single mix", got, exp_q.pop_front());
        wait_frame(got);
        check_frame("frame after single mix", got, '0);
    endtask

    task automatic speaker_gating;
        a2audio_pkg::audio_frame_u got;
        @(negedge clk_logic_w);
        push_sample(1'b1, 1'b0, 10'h155, 10'h0a3, 10'h2f0);
        sample_valid_i = 1'b0;
        wait_nonzero("speaker gating", got);
        check_frame("gated speaker", got, exp_q.pop_front());
        // Removing the Mockingboard terms must leave equal channels
        check_flag("channels differ only by mockingboard",
                   int'(got.ch.left) - 8 * 'h0a3 == int'(got.ch.right) - 8 * 'h2f0, 1'b1);
        wait_frame(got);
        check_frame("frame after gated mix", got, '0);
    endtask

    task automatic burst_ordering;
        a2audio_pkg::audio_frame_u got;
        @(negedge i2s_lrclk_o);
        frames_q.delete();
        @(negedge clk_logic_w);
        push_sample(1'b1, 1'b1, 10'h010, 10'h020, 10'h030);
        push_sample(1'b0, 1'b1, 10'h3ff, 10'h000, 10'h155);
        push_sample(1'b1, 1'b0, 10'h0aa, 10'h2aa, 10'h001);
        push_sample(1'b1, 1'b1, 10'h200, 10'h3ff, 10'h3ff);
        sample_valid_i = 1'b0;
        wait_frame(got);
        check_frame("frame in progress", got, '0);
        repeat (4) begin
            wait_frame(got);
            check_frame("ordered frame", got, exp_q.pop_front());
        end
        wait_frame(got);
        check_frame("frame after burst", got, '0);
        check_flag("burst of four overflow", overflow_o, 1'b0);
    endtask

    task automatic burst_overflow;
        a2audio_pkg::audio_frame_u got;
        apply_reset();
        @(negedge i2s_lrclk_o);
        frames_q.delete();
        @(negedge clk_logic_w);
        push_sample(1'b0, 1'b0, 10'h001, 10'h002, 10'h003);
        push_sample(1'b1, 1'b1, 10'h011, 10'h022, 10'h033);
        push_sample(1'b0, 1'b1, 10'h101, 10'h102, 10'h103);
        push_sample(1'b1, 1'b1, 10'h301, 10'h202, 10'h0f3);
        push_sample(1'b1, 1'b1, 10'h3ff, 10'h3ff, 10'h3ff);
        push_sample(1'b1, 1'b1, 10'h0ff, 10'h1ff, 10'h2ff);
        sample_valid_i = 1'b0;
        repeat (2) @(negedge clk_logic_w);
        check_flag("overflow after six writes", overflow_o, 1'b1);
        wait_frame(got);
        check_frame("frame in progress", got, '0);
        repeat (4) begin
            wait_frame(got);
            check_frame("kept frame", got, exp_q.pop_front());
        end
        exp_q.delete();
        wait_frame(got);
        check_frame("frame after kept four", got, '0);
        check_flag("overflow stays set", overflow_o, 1'b1);
    endtask

    task automatic random_stream;
        a2audio_pkg::audio_frame_u got;
        logic [31:0]               r;
        for (int i = 0; i < 12; i++) begin
            @(negedge i2s_lrclk_o);
            if (i == 0) begin
                frames_q.delete();
            end
            @(negedge clk_logic_w);
            rng_state = xorshift32(rng_state);
            r         = rng_state;
            push_sample(r[0], r[1], r[11:2], r[21:12], r[31:22]);
            sample_valid_i = 1'b0;
        end
        wait_frame(got);
        check_frame("random lead frame", got, '0);
        repeat (12) begin
            wait_frame(got);
            check_frame("random frame", got, exp_q.pop_front());
        end
    endtask

    initial begin
        system_reset_n_w = 1'b0;
        sample_valid_i   = 1'b0;
        speaker_i        = 1'b0;
        speaker_en_i     = 1'b0;
        ssp_audio_i      = '0;
        mb_audio_l_i     = '0;
        mb_audio_r_i     = '0;
        rx_shift         = '0;
        rx_bit           = 0;
        rng_state        = 32'd27692;
        cycle_cnt        = 0;
        frame_errs       = 0;
        flag_errs        = 0;
        other_errs       = 0;
        apply_reset();
        idle_after_reset();
        single_mix();
        speaker_gating();
        burst_ordering();
        burst_overflow();
        random_stream();
        $display("error counts: frame %0d, flag %0d, other %0d", frame_errs, flag_errs,
                 other_errs);
        if (frame_errs + flag_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hw
hw/a2audio_pkg.sv
hw/audio_mixer.sv
hw/sample_fifo.sv
hw/i2s_serializer.sv
hw/a2audio_top.sv
bench/a2audio_tb.sv
